/* armCtrlPkg.sv */
`default_nettype none

package armCtrlPkg;

  // ==================================================
  // Widths and register numbers
  // ==================================================
  localparam int INSTR_WIDTH = 32;  // Instruction and address word
  localparam int FLAGS_WIDTH = 4;   // NZCV
  localparam int PC_REG      = 15;  // R15 is the program counter

  typedef logic [INSTR_WIDTH-1:0] instrT;
  typedef logic [FLAGS_WIDTH-1:0] flagsT;     // N in bit 3 down to V in bit 0
  typedef logic [3:0]             condT;      // Bits 31:28 of the instruction
  typedef logic [3:0]             byteMaskT;  // One enable per byte lane
  typedef logic [1:0]             byteOffT;   // Low address bits
  typedef logic [1:0]             srcSelT;    // Register or immediate source select

  // ==================================================
  // Encodings
  // ==================================================
  // Data-processing opcode, bits 24:21
  typedef enum logic [3:0] {
    OP_AND = 4'h0, OP_EOR = 4'h1, OP_SUB = 4'h2, OP_RSB = 4'h3,
    OP_ADD = 4'h4, OP_ADC = 4'h5, OP_SBC = 4'h6, OP_RSC = 4'h7,
    OP_TST = 4'h8, OP_TEQ = 4'h9, OP_CMP = 4'hA, OP_CMN = 4'hB,
    OP_ORR = 4'hC, OP_MOV = 4'hD, OP_BIC = 4'hE, OP_MVN = 4'hF
  } aluOpT;

  // Condition field
  typedef enum logic [3:0] {
    COND_EQ = 4'h0, COND_NE = 4'h1, COND_CS = 4'h2, COND_CC = 4'h3,
    COND_MI = 4'h4, COND_PL = 4'h5, COND_VS = 4'h6, COND_VC = 4'h7,
    COND_HI = 4'h8, COND_LS = 4'h9, COND_GE = 4'hA, COND_LT = 4'hB,
    COND_GT = 4'hC, COND_LE = 4'hD, COND_AL = 4'hE, COND_NV = 4'hF
  } condCodeT;

  // Instruction class straight from bits 27:26
  typedef enum logic [1:0] {
    DATA_PROC  = 2'b00,
    LOAD_STORE = 2'b01,
    BRANCH     = 2'b10,
    NONE       = 2'b11   // Decodes as no-op
  } instrClassT;

  // Source selects per class
  localparam srcSelT REG_SRC_DEF = 2'b00;  // Rn and Rm from the register file
  localparam srcSelT REG_SRC_BR  = 2'b01;  // Rn read as PC
  localparam srcSelT REG_SRC_STR = 2'b10;  // Rd read as store data
  localparam srcSelT IMM_SRC_DP  = 2'b00;  // 8-bit rotated immediate
  localparam srcSelT IMM_SRC_MEM = 2'b01;  // 12-bit offset
  localparam srcSelT IMM_SRC_BR  = 2'b10;  // 24-bit word offset

endpackage

`default_nettype wire

/* execCtrlIf.sv */
`default_nettype none

// Decode-to-execute control bundle, registered in decodeStage
interface execCtrlIf;

  armCtrlPkg::condT  condE;        // Condition field
  armCtrlPkg::aluOpT aluControlE;  // ALU operation
  logic              flagWriteE;   // S bit of a data-processing op
  logic              aluSrcE;      // Immediate operand B
  logic              regWriteE;
  logic              memWriteE;
  logic              memtoRegE;    // Load result to register
  logic              branchE;
  logic              pcSrcE;       // Writes the PC
  logic              isMemE;       // Single load or store
  logic              isByteE;      // Byte access

  modport decoder (
    output condE, aluControlE, flagWriteE, aluSrcE, regWriteE, memWriteE,
    output memtoRegE, branchE, pcSrcE, isMemE, isByteE
  );

  modport cond   (input condE, aluControlE, flagWriteE);
  modport mem    (input isMemE, isByteE, memtoRegE);
  modport commit (input regWriteE, memWriteE, memtoRegE, branchE, pcSrcE);

endinterface

`default_nettype wire

/* decodeStage.sv */
`default_nettype none

module decodeStage (
  input  logic               clk,
  input  logic               arstN,
  input  logic               stallE,
  input  logic               flushE,
  input  armCtrlPkg::instrT  instrD,
  output armCtrlPkg::srcSelT regSrcD,
  output armCtrlPkg::srcSelT immSrcD,
  execCtrlIf.decoder         ctrl
);

  armCtrlPkg::instrClassT classD;
  armCtrlPkg::aluOpT      aluControlD;
  logic                   aluSrcD;
  logic                   flagWriteD;
  logic                   regWriteD;
  logic                   memWriteD;
  logic                   memtoRegD;
  logic                   branchD;
  logic                   pcSrcD;
  logic                   isMemD;
  logic                   isByteD;

  // ==================================================
  // Decode
  // ==================================================
  assign classD = armCtrlPkg::instrClassT'(instrD[27:26]);

  always_comb begin
    regSrcD     = armCtrlPkg::REG_SRC_DEF;
    immSrcD     = armCtrlPkg::IMM_SRC_DP;
    aluSrcD     = 1'b0;
    aluControlD = armCtrlPkg::OP_ADD;  // Address and target calc add
    flagWriteD  = 1'b0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    memtoRegD   = 1'b0;
    branchD     = 1'b0;
    isMemD      = 1'b0;
    isByteD     = 1'b0;
    case (classD)
      armCtrlPkg::DATA_PROC: begin
        aluSrcD     = instrD[25];                         // I bit
        aluControlD = armCtrlPkg::aluOpT'(instrD[24:21]);
        flagWriteD  = instrD[20];                         // S bit
        regWriteD   = (instrD[24:23] != 2'b10);           // TST TEQ CMP CMN write no Rd
      end
      armCtrlPkg::LOAD_STORE: begin
        immSrcD = armCtrlPkg::IMM_SRC_MEM;
        aluSrcD = ~instrD[25];  // I set means register offset
        isMemD  = 1'b1;
        isByteD = instrD[22];   // B bit
        // U bit picks the offset direction
        if (instrD[23]) begin
          aluControlD = armCtrlPkg::OP_ADD;
        end else begin
          aluControlD = armCtrlPkg::OP_SUB;
        end
        if (instrD[20]) begin   // Load
          memtoRegD = 1'b1;
          regWriteD = 1'b1;
        end else begin          // Store
          memWriteD = 1'b1;
          regSrcD   = armCtrlPkg::REG_SRC_STR;
        end
      end
      armCtrlPkg::BRANCH: begin
        regSrcD = armCtrlPkg::REG_SRC_BR;
        immSrcD = armCtrlPkg::IMM_SRC_BR;
        aluSrcD = 1'b1;   // PC plus offset
        branchD = 1'b1;
      end
      armCtrlPkg::NONE: begin
        // No-op, defaults stand
      end
    endcase
  end

  // Branch or a write to R15
  assign pcSrcD = branchD | (regWriteD & (instrD[15:12] == 4'(armCtrlPkg::PC_REG)));

  // ==================================================
  // Decode to execute register
  // ==================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrl.condE       <= '0;
      ctrl.aluControlE <= armCtrlPkg::OP_AND;
      ctrl.flagWriteE  <= 1'b0;
      ctrl.aluSrcE     <= 1'b0;
      ctrl.regWriteE   <= 1'b0;
      ctrl.memWriteE   <= 1'b0;
      ctrl.memtoRegE   <= 1'b0;
      ctrl.branchE     <= 1'b0;
      ctrl.pcSrcE      <= 1'b0;
      ctrl.isMemE      <= 1'b0;
      ctrl.isByteE     <= 1'b0;
    end else if (!stallE) begin
      if (flushE) begin            // Bubble
        ctrl.condE       <= '0;
        ctrl.aluControlE <= armCtrlPkg::OP_AND;
        ctrl.flagWriteE  <= 1'b0;
        ctrl.aluSrcE     <= 1'b0;
        ctrl.regWriteE   <= 1'b0;
        ctrl.memWriteE   <= 1'b0;
        ctrl.memtoRegE   <= 1'b0;
        ctrl.branchE     <= 1'b0;
        ctrl.pcSrcE      <= 1'b0;
        ctrl.isMemE      <= 1'b0;
        ctrl.isByteE     <= 1'b0;
      end else begin
        ctrl.condE       <= instrD[31:28];
        ctrl.aluControlE <= aluControlD;
        ctrl.flagWriteE  <= flagWriteD;
        ctrl.aluSrcE     <= aluSrcD;
        ctrl.regWriteE   <= regWriteD;
        ctrl.memWriteE   <= memWriteD;
        ctrl.memtoRegE   <= memtoRegD;
        ctrl.branchE     <= branchD;
        ctrl.pcSrcE      <= pcSrcD;
        ctrl.isMemE      <= isMemD;
        ctrl.isByteE     <= isByteD;
      end
    end
  end

endmodule

`default_nettype wire

/* condCheck.sv */
`default_nettype none

module condCheck (
  execCtrlIf.cond           ctrl,
  input  armCtrlPkg::flagsT flagsE,      // Forwarded NZCV
  input  armCtrlPkg::flagsT aluFlagsE,   // Flags from the ALU this cycle
  output logic              condExE,
  output logic              setFlagsE,
  output armCtrlPkg::flagsT flagsNextE
);

  logic nFlag;
  logic zFlag;
  logic cFlag;
  logic vFlag;
  logic arithE;   // Op produces its own C and V

  assign {nFlag, zFlag, cFlag, vFlag} = flagsE;

  // ==================================================
  // Condition table
  // ==================================================
  always_comb begin
    case (armCtrlPkg::condCodeT'(ctrl.condE))
      armCtrlPkg::COND_EQ: condExE = zFlag;
      armCtrlPkg::COND_NE: condExE = ~zFlag;
      armCtrlPkg::COND_CS: condExE = cFlag;
      armCtrlPkg::COND_CC: condExE = ~cFlag;
      armCtrlPkg::COND_MI: condExE = nFlag;
      armCtrlPkg::COND_PL: condExE = ~nFlag;
      armCtrlPkg::COND_VS: condExE = vFlag;
      armCtrlPkg::COND_VC: condExE = ~vFlag;
      armCtrlPkg::COND_HI: condExE = cFlag & ~zFlag;             // Unsigned higher
      armCtrlPkg::COND_LS: condExE = ~cFlag | zFlag;
      armCtrlPkg::COND_GE: condExE = (nFlag == vFlag);           // Signed
      armCtrlPkg::COND_LT: condExE = (nFlag != vFlag);
      armCtrlPkg::COND_GT: condExE = ~zFlag & (nFlag == vFlag);
      armCtrlPkg::COND_LE: condExE = zFlag | (nFlag != vFlag);
      armCtrlPkg::COND_AL: condExE = 1'b1;
      armCtrlPkg::COND_NV: condExE = 1'b0;                        // Never
    endcase
  end

  // Adder ops own C and V, logic ops leave them alone
  always_comb begin
    case (ctrl.aluControlE)
      armCtrlPkg::OP_SUB, armCtrlPkg::OP_RSB,
      armCtrlPkg::OP_ADD, armCtrlPkg::OP_ADC,
      armCtrlPkg::OP_SBC, armCtrlPkg::OP_RSC,
      armCtrlPkg::OP_CMP, armCtrlPkg::OP_CMN: arithE = 1'b1;
      default:                                arithE = 1'b0;
    endcase
  end

  // ==================================================
  // Next flags
  // ==================================================
  always_comb begin
    flagsNextE = flagsE;
    if (ctrl.flagWriteE) begin
      flagsNextE[3:2] = aluFlagsE[3:2];          // N and Z always
      if (arithE) begin
        flagsNextE[1:0] = aluFlagsE[1:0];
      end
    end
  end

  assign setFlagsE = ctrl.flagWriteE & condExE;  // Failed condition keeps flags

endmodule

`default_nettype wire

/* memAccessDecode.sv */
`default_nettype none

module memAccessDecode (
  execCtrlIf.mem               ctrl,
  input  armCtrlPkg::instrT    aluResultE,   // Effective address
  output armCtrlPkg::byteMaskT byteMaskE,
  output armCtrlPkg::byteOffT  byteOffsetE,
  output logic                 loadByteE
);

  assign byteOffsetE = aluResultE[1:0];  // Lane within the word

  // Lane enables
  always_comb begin
    if (!ctrl.isMemE) begin
      byteMaskE = 4'b0000;                       // No access
    end else if (ctrl.isByteE) begin
      byteMaskE = 4'b0001 << byteOffsetE;        // Single lane
    end else begin
      byteMaskE = 4'b1111;                       // Full word
    end
  end

  // Byte load needs shift and zero fill at writeback
  assign loadByteE = ctrl.isMemE & ctrl.isByteE & ctrl.memtoRegE;

endmodule

`default_nettype wire

/* stageCommit.sv */
`default_nettype none

module stageCommit #(
  parameter int unsigned FWD_FLAGS = 1
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 stallM,
  input  logic                 stallW,
  input  logic                 flushW,
  execCtrlIf.commit            ctrl,
  input  logic                 condExE,
  input  logic                 setFlagsE,
  input  logic                 loadByteE,
  input  armCtrlPkg::flagsT    flagsNextE,
  input  armCtrlPkg::byteMaskT byteMaskE,
  input  armCtrlPkg::byteOffT  byteOffsetE,
  output armCtrlPkg::flagsT    flagsE,
  output logic                 branchTakenE,
  output logic                 memWriteM,
  output logic                 regWriteW,
  output logic                 memtoRegW,
  output logic                 pcSrcW,
  output logic                 loadByteW,
  output armCtrlPkg::byteMaskT byteMaskM,
  output armCtrlPkg::byteOffT  byteOffsetW
);

  logic                regWriteGE;
  logic                memWriteGE;
  logic                pcSrcGE;
  logic                regWriteM;
  logic                memtoRegM;
  logic                pcSrcM;
  logic                loadByteM;
  logic                setFlagsM;
  logic                setFlagsW;
  armCtrlPkg::byteOffT byteOffsetM;
  armCtrlPkg::flagsT   flagsNextM;
  armCtrlPkg::flagsT   flagsNextW;
  armCtrlPkg::flagsT   flagReg;      // Architectural NZCV

  // ==================================================
  // Execute stage gating
  // ==================================================
  assign branchTakenE = ctrl.branchE & condExE;
  assign regWriteGE   = ctrl.regWriteE & condExE;
  assign memWriteGE   = ctrl.memWriteE & condExE;  // Store squashed on fail
  assign pcSrcGE      = ctrl.pcSrcE & condExE;

  // ==================================================
  // Memory stage
  // ==================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memWriteM <= 1'b0;
      regWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      pcSrcM    <= 1'b0;
      loadByteM <= 1'b0;
      setFlagsM <= 1'b0;
      byteMaskM <= '0;
    end else if (!stallM) begin   // No flush here
      memWriteM <= memWriteGE;
      regWriteM <= regWriteGE;
      memtoRegM <= ctrl.memtoRegE;
      pcSrcM    <= pcSrcGE;
      loadByteM <= loadByteE;
      setFlagsM <= setFlagsE;
      byteMaskM <= byteMaskE;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallM) begin
      byteOffsetM <= byteOffsetE;
      flagsNextM  <= flagsNextE;
    end
  end

  // ==================================================
  // Writeback stage
  // ==================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
      pcSrcW    <= 1'b0;
      loadByteW <= 1'b0;
      setFlagsW <= 1'b0;
    end else if (!stallW) begin
      regWriteW <= regWriteM & ~flushW;
      memtoRegW <= memtoRegM & ~flushW;
      pcSrcW    <= pcSrcM & ~flushW;
      loadByteW <= loadByteM & ~flushW;
      setFlagsW <= setFlagsM & ~flushW;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallW) begin
      byteOffsetW <= byteOffsetM;
      flagsNextW  <= flagsNextM;
    end
  end

  // Flag register commits as writeback closes
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagReg <= '0;
    end else if (setFlagsW && !stallW) begin
      flagReg <= flagsNextW;
    end
  end

  // Youngest pending flag write wins
  always_comb begin
    if ((FWD_FLAGS != 0) && setFlagsM) begin
      flagsE = flagsNextM;
    end else if ((FWD_FLAGS != 0) && setFlagsW) begin
      flagsE = flagsNextW;
    end else begin
      flagsE = flagReg;
    end
  end

endmodule

`default_nettype wire

/* armController.sv */
`default_nettype none

module armController #(
  parameter int unsigned FWD_FLAGS = 1   // Forward flags from M and W
) (
  input  logic                 clk,
  input  logic                 arstN,
  // Hazard unit
  input  logic                 stallE,
  input  logic                 flushE,
  input  logic                 stallM,
  input  logic                 stallW,
  input  logic                 flushW,
  // Datapath
  input  armCtrlPkg::instrT    instrD,
  input  armCtrlPkg::flagsT    aluFlagsE,
  input  armCtrlPkg::instrT    aluResultE,
  output armCtrlPkg::srcSelT   regSrcD,
  output armCtrlPkg::srcSelT   immSrcD,
  output armCtrlPkg::aluOpT    aluControlE,
  output logic                 aluSrcE,
  output logic                 branchTakenE,
  output armCtrlPkg::flagsT    flagsE,
  output logic                 memWriteM,
  output armCtrlPkg::byteMaskT byteMaskM,
  output logic                 regWriteW,
  output logic                 memtoRegW,
  output logic                 pcSrcW,
  output logic                 loadByteW,
  output armCtrlPkg::byteOffT  byteOffsetW
);

  logic                 condExE;
  logic                 setFlagsE;
  logic                 loadByteE;
  armCtrlPkg::flagsT    flagsNextE;
  armCtrlPkg::byteMaskT byteMaskE;
  armCtrlPkg::byteOffT  byteOffsetE;

  execCtrlIf ctrlBus ();   // Registered execute controls

  assign aluControlE = ctrlBus.aluControlE;
  assign aluSrcE     = ctrlBus.aluSrcE;

  // ==================================================
  // Decode and execute register
  // ==================================================
  decodeStage decode_i (
    .clk     (clk),
    .arstN   (arstN),
    .stallE  (stallE),
    .flushE  (flushE),
    .instrD  (instrD),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD),
    .ctrl    (ctrlBus.decoder)
  );

  // ==================================================
  // Execute side by side blocks
  // ==================================================
  condCheck cond_i (
    .ctrl       (ctrlBus.cond),
    .flagsE     (flagsE),
    .aluFlagsE  (aluFlagsE),
    .condExE    (condExE),
    .setFlagsE  (setFlagsE),
    .flagsNextE (flagsNextE)
  );

  memAccessDecode memDec_i (
    .ctrl        (ctrlBus.mem),
    .aluResultE  (aluResultE),
    .byteMaskE   (byteMaskE),
    .byteOffsetE (byteOffsetE),
    .loadByteE   (loadByteE)
  );

  // Gating, M and W registers, flags
  stageCommit #(
    .FWD_FLAGS (FWD_FLAGS)
  ) commit_i (
    .clk          (clk),
    .arstN        (arstN),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushW       (flushW),
    .ctrl         (ctrlBus.commit),
    .condExE      (condExE),
    .setFlagsE    (setFlagsE),
    .loadByteE    (loadByteE),
    .flagsNextE   (flagsNextE),
    .byteMaskE    (byteMaskE),
    .byteOffsetE  (byteOffsetE),
    .flagsE       (flagsE),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .regWriteW    (regWriteW),
    .memtoRegW    (memtoRegW),
    .pcSrcW       (pcSrcW),
    .loadByteW    (loadByteW),
    .byteMaskM    (byteMaskM),
    .byteOffsetW  (byteOffsetW)
  );

endmodule

`default_nettype wire

/* tbClockGen.sv */
`default_nettype none

// Free running testbench clock
module tbClockGen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;   // Half period high, half low
  end

endmodule

`default_nettype wire

/* tbArmController.sv */
`default_nettype none

module tbArmController;

  localparam armCtrlPkg::instrT NOP_WORD = 32'hEC00_0000;  // Class 11 decodes as no-op
  localparam int MAX_CYCLES = 400;  // About four times the directed test length

  logic clk;
  logic arstN;
  logic stallE;
  logic flushE;
  logic stallM;
  logic stallW;
  logic flushW;
  armCtrlPkg::instrT    instrD;
  armCtrlPkg::flagsT    aluFlagsE;
  armCtrlPkg::instrT    aluResultE;
  armCtrlPkg::srcSelT   regSrcD;
  armCtrlPkg::srcSelT   immSrcD;
  armCtrlPkg::aluOpT    aluControlE;
  logic                 aluSrcE;
  logic                 branchTakenE;
  armCtrlPkg::flagsT    flagsE;
  logic                 memWriteM;
  armCtrlPkg::byteMaskT byteMaskM;
  logic                 regWriteW;
  logic                 memtoRegW;
  logic                 pcSrcW;
  logic                 loadByteW;
  armCtrlPkg::byteOffT  byteOffsetW;

  int                errCount = 0;
  int                checkCount = 0;
  int                cycleCount = 0;
  integer            seed = 32044;
  armCtrlPkg::flagsT flagModel = '0;   // Expected architectural NZCV

  tbClockGen #(.PERIOD(40)) clkGen_i (.clk(clk));

  armController #(.FWD_FLAGS(1)) dut_i (
    .clk(clk), .arstN(arstN),
    .stallE(stallE), .flushE(flushE), .stallM(stallM), .stallW(stallW), .flushW(flushW),
    .instrD(instrD), .aluFlagsE(aluFlagsE), .aluResultE(aluResultE),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluControlE(aluControlE), .aluSrcE(aluSrcE),
    .branchTakenE(branchTakenE), .flagsE(flagsE), .memWriteM(memWriteM),
    .byteMaskM(byteMaskM), .regWriteW(regWriteW), .memtoRegW(memtoRegW),
    .pcSrcW(pcSrcW), .loadByteW(loadByteW), .byteOffsetW(byteOffsetW)
  );

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic checkFlags(input string name, input armCtrlPkg::flagsT got,
                            input armCtrlPkg::flagsT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkMask(input string name, input armCtrlPkg::byteMaskT got,
                           input armCtrlPkg::byteMaskT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkOff(input string name, input armCtrlPkg::byteOffT got,
                          input armCtrlPkg::byteOffT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkSel(input string name, input armCtrlPkg::srcSelT got,
                          input armCtrlPkg::srcSelT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkOp(input string name, input armCtrlPkg::aluOpT got,
                         input armCtrlPkg::aluOpT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // ==================================================
  // Reference model and instruction builders
  // ==================================================
  function automatic armCtrlPkg::srcSelT refRegSrc(input armCtrlPkg::instrT ins);
    if (ins[27:26] == 2'b10) return 2'b01;                     // Branch reads PC
    if (ins[27:26] == 2'b01 && !ins[20]) return 2'b10;         // Store reads Rd
    return 2'b00;
  endfunction

  function automatic armCtrlPkg::srcSelT refImmSrc(input armCtrlPkg::instrT ins);
    if (ins[27:26] == 2'b01) return 2'b01;
    if (ins[27:26] == 2'b10) return 2'b10;
    return 2'b00;
  endfunction

  function automatic armCtrlPkg::aluOpT refAluOp(input armCtrlPkg::instrT ins);
    if (ins[27:26] == 2'b00) return armCtrlPkg::aluOpT'(ins[24:21]);
    if (ins[27:26] == 2'b01 && !ins[23]) return armCtrlPkg::OP_SUB;  // Down offset
    return armCtrlPkg::OP_ADD;
  endfunction

  function automatic logic refAluSrc(input armCtrlPkg::instrT ins);
    case (ins[27:26])
      2'b00:   return ins[25];
      2'b01:   return !ins[25];
      2'b10:   return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic refRegWrite(input armCtrlPkg::instrT ins);
    if (ins[27:26] == 2'b00) return !(ins[24:21] >= 4'h8 && ins[24:21] <= 4'hB);
    if (ins[27:26] == 2'b01) return ins[20];                   // Loads only
    return 1'b0;
  endfunction

  function automatic logic refPcSrc(input armCtrlPkg::instrT ins);
    return (ins[27:26] == 2'b10) || (refRegWrite(ins) && ins[15:12] == 4'hF);
  endfunction

  // Odd codes are the inverse of the even code below them
  function automatic logic condPasses(input logic [3:0] cond, input armCtrlPkg::flagsT f);
    logic n;
    logic z;
    logic c;
    logic v;
    logic base;
    {n, z, c, v} = f;
    case (cond[3:1])
      3'd0:    base = z;
      3'd1:    base = c;
      3'd2:    base = n;
      3'd3:    base = v;
      3'd4:    base = c && !z;
      3'd5:    base = (n == v);
      3'd6:    base = !z && (n == v);
      default: base = 1'b1;   // AL true and NV its inverse
    endcase
    return cond[0] ? !base : base;
  endfunction

  function automatic armCtrlPkg::byteMaskT refMask(input logic isByte,
                                                   input armCtrlPkg::byteOffT off);
    if (!isByte) begin
      return 4'hF;
    end else begin
      return {off == 2'd3, off == 2'd2, off == 2'd1, off == 2'd0};
    end
  endfunction

  function automatic armCtrlPkg::instrT dpWord(input logic [3:0] cond, input logic [3:0] op,
                                               input logic s, input logic imm,
                                               input logic [3:0] rd);
    return {cond, 2'b00, imm, op, s, 4'h2, rd, 12'h005};
  endfunction

  function automatic armCtrlPkg::instrT memWord(input logic [3:0] cond, input logic load,
                                                input logic isByte, input logic up,
                                                input logic regOff, input logic [3:0] rd);
    return {cond, 2'b01, regOff, 1'b1, up, isByte, 1'b0, load, 4'h3, rd, 12'h004};
  endfunction

  function automatic armCtrlPkg::instrT brWord(input logic [3:0] cond);
    return {cond, 4'b1010, 24'h000010};
  endfunction

  // ==================================================
  // Timing helpers
  // ==================================================
  task automatic nextCycle();
    @(posedge clk);
    #2;   // Drive point
  endtask

  task automatic settle();
    @(negedge clk);   // Sample point mid cycle
  endtask

  task automatic drawRandom(output logic [31:0] r);
    r = $random(seed);
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic testDecodeSelects();
    armCtrlPkg::instrT words[5];
    armCtrlPkg::instrT prev;
    words = '{dpWord(4'hE, 4'h4, 1'b0, 1'b1, 4'h1),     // ADD imm
              dpWord(4'hE, 4'hA, 1'b0, 1'b0, 4'h0),     // CMP reg
              memWord(4'hE, 1'b1, 1'b0, 1'b0, 1'b1, 4'h2),   // LDR down with reg offset
              memWord(4'hE, 1'b0, 1'b1, 1'b1, 1'b0, 4'h6),   // STRB up with imm offset
              brWord(4'hE)};
    instrD = NOP_WORD;
    nextCycle();
    prev = NOP_WORD;
    for (int i = 0; i <= 5; i++) begin
      instrD = (i < 5) ? words[i] : NOP_WORD;
      settle();
      checkSel("regSrcD", regSrcD, refRegSrc(instrD));
      checkSel("immSrcD", immSrcD, refImmSrc(instrD));
      checkOp("aluControlE", aluControlE, refAluOp(prev));   // Previous word now in E
      checkBit("aluSrcE", aluSrcE, refAluSrc(prev));
      prev = instrD;
      nextCycle();
    end
  endtask

  task automatic testCondBranches();
    logic [31:0]       rnd;
    armCtrlPkg::flagsT f;
    logic [3:0]        bc[3];
    for (int k = 0; k < 6; k++) begin
      drawRandom(rnd);
      f = rnd[3:0];
      for (int j = 0; j < 3; j++) begin
        bc[j] = rnd[8 + 4 * j +: 4];
      end
      instrD = dpWord(4'hE, 4'hA, 1'b1, 1'b0, 4'h0);   // CMPS
      nextCycle();
      aluFlagsE = f;                                    // CMP result in execute
      instrD = brWord(bc[0]);
      nextCycle();
      for (int j = 0; j < 3; j++) begin
        aluFlagsE = ~f;                                 // Branches set no flags
        instrD = (j < 2) ? brWord(bc[j + 1]) : NOP_WORD;
        settle();
        checkFlags("flagsE", flagsE, f);               // From M, then W, then register
        checkBit("branchTakenE", branchTakenE, condPasses(bc[j], f));
        nextCycle();
      end
      flagModel = f;
    end
  endtask

  task automatic testStoreMask();
    logic [31:0] rnd;
    logic [3:0]  cond;
    for (int k = 0; k < 8; k++) begin
      drawRandom(rnd);
      cond = (k < 4) ? 4'hE : rnd[31:28];
      if (k >= 6 && condPasses(cond, flagModel)) begin
        cond[0] = ~cond[0];                             // Inverse code squashes the store
      end
      instrD = memWord(cond, 1'b0, rnd[4], 1'b1, 1'b0, 4'h5);
      nextCycle();
      instrD = NOP_WORD;
      aluResultE = rnd;                                 // Store address
      nextCycle();
      settle();
      checkMask("byteMaskM", byteMaskM, refMask(rnd[4], rnd[1:0]));
      checkBit("memWriteM", memWriteM, condPasses(cond, flagModel));
      nextCycle();
    end
  endtask

  task automatic testWriteback();
    armCtrlPkg::instrT words[4];
    logic [31:0]       rnd;
    words = '{memWord(4'hE, 1'b1, 1'b1, 1'b1, 1'b0, 4'h3),   // LDRB
              memWord(4'hE, 1'b1, 1'b0, 1'b1, 1'b0, 4'hF),   // LDR to PC
              dpWord(4'hE, 4'hD, 1'b0, 1'b1, 4'hF),          // MOV PC
              dpWord(4'hE, 4'hA, 1'b0, 1'b0, 4'h0)};         // CMP
    for (int i = 0; i < 4; i++) begin
      drawRandom(rnd);
      instrD = words[i];
      nextCycle();
      instrD = NOP_WORD;
      aluResultE = rnd;
      nextCycle();
      nextCycle();
      settle();
      checkBit("regWriteW", regWriteW, refRegWrite(words[i]));
      checkBit("memtoRegW", memtoRegW, (words[i][27:26] == 2'b01) && words[i][20]);
      checkBit("pcSrcW", pcSrcW, refPcSrc(words[i]));
      checkBit("loadByteW", loadByteW,
               (words[i][27:26] == 2'b01) && words[i][20] && words[i][22]);
      checkOff("byteOffsetW", byteOffsetW, rnd[1:0]);
      nextCycle();
    end
  endtask

  task automatic testLogicalFlags();
    logic [31:0]       rnd;
    armCtrlPkg::flagsT exp;
    for (int k = 0; k < 3; k++) begin
      drawRandom(rnd);
      exp = {rnd[7:6], rnd[1:0]};   // N Z from ANDS with C V kept from CMPS
      instrD = dpWord(4'hE, 4'hA, 1'b1, 1'b0, 4'h0);   // CMPS
      nextCycle();
      aluFlagsE = rnd[3:0];
      instrD = dpWord(4'hE, 4'h0, 1'b1, 1'b1, 4'h4);   // ANDS
      nextCycle();
      aluFlagsE = rnd[7:4];
      instrD = NOP_WORD;
      nextCycle();
      settle();
      checkFlags("flagsE", flagsE, exp);
      nextCycle();
      nextCycle();
      settle();
      checkFlags("flagsE", flagsE, exp);   // Retired into the register
      flagModel = exp;
      nextCycle();
    end
  endtask

  task automatic testStallFlush();
    armCtrlPkg::instrT flushed[2];
    flushed = '{brWord(4'hE), dpWord(4'hE, 4'hD, 1'b0, 1'b1, 4'hF)};
    instrD = dpWord(4'hE, 4'h4, 1'b0, 1'b1, 4'h1);     // ADD imm
    nextCycle();
    instrD = dpWord(4'hE, 4'h2, 1'b0, 1'b0, 4'h1);     // SUB reg waits in decode
    stallE = 1'b1;
    settle();
    checkOp("aluControlE", aluControlE, armCtrlPkg::OP_ADD);
    nextCycle();
    stallE = 1'b0;
    settle();
    checkOp("aluControlE", aluControlE, armCtrlPkg::OP_ADD);   // Held
    checkBit("aluSrcE", aluSrcE, 1'b1);
    nextCycle();
    instrD = NOP_WORD;
    settle();
    checkOp("aluControlE", aluControlE, armCtrlPkg::OP_SUB);
    checkBit("aluSrcE", aluSrcE, 1'b0);
    nextCycle();
    // Execute flush turns a branch and a PC write into bubbles
    for (int i = 0; i < 2; i++) begin
      instrD = flushed[i];
      flushE = 1'b1;
      nextCycle();
      flushE = 1'b0;
      instrD = NOP_WORD;
      settle();
      checkBit("branchTakenE", branchTakenE, 1'b0);
      nextCycle();
      nextCycle();
      settle();
      checkBit("regWriteW", regWriteW, 1'b0);
      checkBit("pcSrcW", pcSrcW, 1'b0);
      nextCycle();
    end
    // Writeback flush on a MOV
    instrD = dpWord(4'hE, 4'hD, 1'b0, 1'b1, 4'h1);
    nextCycle();
    instrD = NOP_WORD;
    nextCycle();
    flushW = 1'b1;                                     // MOV sits in memory stage
    nextCycle();
    flushW = 1'b0;
    settle();
    checkBit("regWriteW", regWriteW, 1'b0);
    nextCycle();
  endtask

  // ==================================================
  // Run control
  // ==================================================
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not complete (%0d errors so far)",
               cycleCount, errCount);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    arstN = 1'b0;
    stallE = 1'b0;
    flushE = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    flushW = 1'b0;
    instrD = NOP_WORD;
    aluFlagsE = '0;
    aluResultE = '0;
    repeat (5) @(posedge clk);   // Reset for 5 cycles
    #2;
    arstN = 1'b1;
    testDecodeSelects();
    testCondBranches();
    testStoreMask();
    testWriteback();
    testLogicalFlags();
    testStallFlush();
    $display("Summary: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
armCtrlPkg.sv
execCtrlIf.sv
decodeStage.sv
condCheck.sv
memAccessDecode.sv
stageCommit.sv
armController.sv
tbClockGen.sv
tbArmController.sv

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f flist.f --top-module tbArmController -o tbSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tbSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
